//--- Makefile
# Verilator build and run of the Z80 clock testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails if the log reports a failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --top-module tb_zclock -f verilog.f -o sim_zclock
	./obj_dir/sim_zclock | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/tb_zclock.sv
// testbench top for the Z80 clock subsystem
// a table of rows is applied in order, each row opens a checker window
// inputs change with non-blocking assignments on the fclk rising edge

`timescale 1ns/10ps

module tb_zclock;

	import zclk_pkg::*;

	localparam int IO_WAIT_LEN = 12;
	localparam int ROWS        = 12;
	localparam int TIMEOUT     = 64;
	localparam logic [1:0] CYC_NONE = 2'd0;
	localparam logic [1:0] CYC_IO   = 2'd1;
	localparam logic [1:0] CYC_MEM  = 2'd2;

	// one row of stimulus and expected values
	typedef struct packed
	{
		logic [95:0] name;
		turbo_t      turbo;
		logic        rfsh;
		logic [1:0]  cyc;
		logic        ext_port;
		logic        m1_n;
		logic [2:0]  hold;
		logic [4:0]  period;
		logic [4:0]  gap;
		turbo_t      exp_turbo;
	} stim_t;

	logic     fclk = 1'b0;
	logic     rst_n;
	turbo_t   turbo;
	zbus_t    bus;
	logic     external_port;
	logic     dram_busy;
	logic     zclk_out;
	zedge_t   edges;
	turbo_t   int_turbo;
	logic     cpu_grant;
	logic     active;
	stim_t    cur;
	stim_t    table_rows [ROWS];
	int       row_cnt;
	logic [31:0] lcg_state;
	logic     timed_out;

	always #10 fclk = ~fclk;

	zclock_top #(
		.IO_WAIT_LEN (IO_WAIT_LEN)
	) zclock_top_i (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.turbo         (turbo),
		.bus           (bus),
		.external_port (external_port),
		.dram_busy     (dram_busy),
		.zclk_out      (zclk_out),
		.edges         (edges),
		.int_turbo     (int_turbo),
		.cpu_grant     (cpu_grant)
	);

	zclock_checker zclock_checker_i (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.edges      (edges),
		.zclk_out   (zclk_out),
		.int_turbo  (int_turbo),
		.cpu_grant  (cpu_grant),
		.bus        (bus),
		.dram_busy  (dram_busy),
		.active     (active),
		.test_name  (cur.name),
		.exp_period (int'(cur.period)),
		.exp_gap    (int'(cur.gap)),
		.exp_turbo  (cur.exp_turbo),
		.exp_grant  (cur.cyc == CYC_MEM)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_row(input logic [95:0] name, input turbo_t t, input logic rfsh,
		input logic [1:0] cyc, input logic ext, input logic m1_n, input logic [2:0] hold,
		input logic [4:0] period, input logic [4:0] gap, input turbo_t exp_t);
		stim_t r;
		r = '{name, t, rfsh, cyc, ext, m1_n, hold, period, gap, exp_t};
		table_rows[row_cnt] = r;
		row_cnt++;
	endtask

	// count zpos strobes, give up after a bounded number of cycles
	task automatic wait_zpos(input int count);
		int n;
		int t;
		n = 0;
		t = 0;
		while (n < count && !timed_out)
		begin
			@(posedge fclk);
			t++;
			if (edges.zpos)
				n++;
			if (t > TIMEOUT * count)
			begin
				$display("timeout while waiting for zpos in test %0s", cur.name);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_grant(input logic level);
		int t;
		t = 0;
		while (cpu_grant != level && !timed_out)
		begin
			@(posedge fclk);
			t++;
			if (t > TIMEOUT)
			begin
				$display("timeout while waiting for cpu_grant in test %0s", cur.name);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_turbo(input turbo_t t_exp);
		int t;
		t = 0;
		while (int_turbo != t_exp && !timed_out)
		begin
			@(posedge fclk);
			t++;
			if (t > TIMEOUT)
			begin
				$display("timeout while waiting for the speed change in test %0s", cur.name);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic run_row(input stim_t r);
		cur   <= r;
		turbo <= r.turbo;
		// refresh pulse seen by one zpos switches the speed
		if (r.rfsh)
		begin
			wait_zpos(1);
			bus.rfsh_n <= 1'b0;
			wait_zpos(1);
			bus.rfsh_n <= 1'b1;
			wait_turbo(r.exp_turbo);
		end
		wait_zpos(3);
		active <= 1'b1;
		wait_zpos(3);
		if (r.cyc == CYC_IO)
		begin
			wait_zpos(1);
			bus.iorq_n    <= 1'b0;
			bus.m1_n      <= r.m1_n;
			external_port <= r.ext_port;
			wait_zpos(3);
			bus.iorq_n    <= 1'b1;
			bus.m1_n      <= 1'b1;
			external_port <= 1'b0;
			wait_zpos(4);
		end
		else if (r.cyc == CYC_MEM)
		begin
			wait_zpos(1);
			bus.mreq_n <= 1'b0;
			dram_busy  <= (r.hold != 3'd0);
			repeat (r.hold) @(posedge fclk);
			dram_busy <= 1'b0;
			wait_grant(1'b1);
			repeat (2) @(posedge fclk);
			bus.mreq_n <= 1'b1;
			wait_grant(1'b0);
			wait_zpos(3);
		end
		@(posedge fclk);
		active <= 1'b0;
		repeat (2) @(posedge fclk);
	endtask

	initial
	begin
		rst_n         = 1'b0;
		turbo         = TURBO_35;
		bus           = '1;
		external_port = 1'b0;
		dram_busy     = 1'b0;
		active        = 1'b0;
		cur           = '0;
		timed_out     = 1'b0;
		row_cnt       = 0;
		lcg_state     = 32'h0061_22d5;

		add_row("reset_35", TURBO_35, 0, CYC_NONE, 0, 1, 0, 8, 0, TURBO_35);
		add_row("no_rfsh_70", TURBO_70, 0, CYC_NONE, 0, 1, 0, 8, 0, TURBO_35);
		add_row("rfsh_70", TURBO_70, 1, CYC_NONE, 0, 1, 0, 4, 0, TURBO_70);
		add_row("io_ext_70", TURBO_70, 0, CYC_IO, 1, 1, 0, 4, 0, TURBO_70);
		add_row("rfsh_140", TURBO_140, 1, CYC_NONE, 0, 1, 0, 2, 0, TURBO_140);
		add_row("io_ext_140", TURBO_140, 0, CYC_IO, 1, 1, 0, 2, 5'(IO_WAIT_LEN), TURBO_140);
		add_row("io_int_140", TURBO_140, 0, CYC_IO, 0, 1, 0, 2, 0, TURBO_140);
		add_row("io_inta_140", TURBO_140, 0, CYC_IO, 1, 0, 0, 2, 0, TURBO_140);
		// random dram_busy holds of 0 to 7 cycles
		for (int k = 0; k < 4; k++)
		begin
			lcg_state = lcg_next(lcg_state);
			add_row({"mem_140_", 8'(48 + k)}, TURBO_140, 0, CYC_MEM, 0, 1,
				lcg_state[18:16], 0, 0, TURBO_140);
		end

		repeat (8) @(posedge fclk);
		rst_n <= 1'b1;

		for (int i = 0; i < ROWS; i++)
		begin
			if (!timed_out)
				run_row(table_rows[i]);
		end
		repeat (3) @(posedge fclk);

		$display("tests passed %0d, failed %0d",
			zclock_checker_i.pass_count, zclock_checker_i.fail_count);
		if (timed_out || zclock_checker_i.fail_count != 0 || zclock_checker_i.errs != 0)
			$display("TEST FAILED");
		else
			$display("TEST OK");
		$finish;
	end

endmodule

//--- verification/zclock_checker.sv
// checker for the Z80 clock subsystem
// watches the DUT ports at every fclk posedge and compares against the clock rules
// the testbench opens a test window with active and the expected values, one line per test

`timescale 1ns/10ps

module zclock_checker
(
	input  logic             fclk,
	input  logic             rst_n,
	input  zclk_pkg::zedge_t edges,
	input  logic             zclk_out,
	input  zclk_pkg::turbo_t int_turbo,
	input  logic             cpu_grant,
	input  zclk_pkg::zbus_t  bus,
	input  logic             dram_busy,
	input  logic             active,
	input  logic [95:0]      test_name,
	input  int               exp_period,
	input  int               exp_gap,
	input  zclk_pkg::turbo_t exp_turbo,
	input  logic             exp_grant
);

	import zclk_pkg::*;

	int   cycle;
	int   last_zpos;
	int   intv;
	int   intervals;
	int   gaps;
	int   grants;
	int   errs = 0;
	int   pass_count = 0;
	int   fail_count = 0;
	logic was_active;
	logic reset_seen;
	logic prev_zclk;
	logic prev_pending;
	logic prev_busy;
	logic prev_mreq_n;
	logic prev_grant;

	task automatic value_error(input string sig, input int got, input int exp);
		$display("Error: %s got 0x%0h expected 0x%0h", sig, got, exp);
		errs++;
	endtask

	task automatic text_error(input string msg);
		$display("%s", msg);
		errs++;
	endtask

	// one line per finished test, errors since the last report count against it
	task automatic report_test(input logic [95:0] name);
		if (errs == 0)
		begin
			pass_count++;
			$display("test %0s: pass", name);
		end
		else
		begin
			fail_count++;
			$display("test %0s: fail with %0d errors", name, errs);
		end
		errs = 0;
	endtask

	always @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cycle       = 0;
			reset_seen  = 1'b1;
			was_active  = 1'b0;
			prev_zclk   = 1'b0;
			prev_pending = 1'b0;
			prev_busy   = 1'b0;
			prev_mreq_n = 1'b1;
			prev_grant  = 1'b0;
		end
		else
		begin
			cycle++;
			// first sample after release still shows the reset state
			if (reset_seen)
			begin
				if (edges != '0)
					value_error("edges", int'(edges), 0);
				if (zclk_out)
					value_error("zclk_out", 1, 0);
				if (cpu_grant)
					value_error("cpu_grant", 1, 0);
				if (int_turbo != TURBO_35)
					value_error("int_turbo", int'(int_turbo), int'(TURBO_35));
				report_test("reset");
				reset_seen = 1'b0;
			end

			// zclk_out follows a strobe on the negedge inside the same strobe cycle
			// zpos leaves it low, zneg high, and it holds between strobes
			if (edges.zpos || edges.zneg)
			begin
				if (zclk_out != edges.zneg)
					value_error("zclk_out", int'(zclk_out), int'(edges.zneg));
				else if (zclk_out == prev_zclk)
					text_error("zclk_out did not toggle at a clock edge strobe");
			end
			else if (zclk_out != prev_zclk)
				value_error("zclk_out", int'(zclk_out), int'(prev_zclk));

			// a waiting memory request allows no edge
			if (prev_pending && (edges.zpos || edges.zneg))
				value_error("edges", int'(edges), 0);
			if (cpu_grant && !prev_grant && prev_busy)
				value_error("dram_busy", 1, 0);
			if (cpu_grant && prev_mreq_n)
				value_error("cpu_grant", 1, 0);

			if (active && !was_active)
			begin
				last_zpos = -1;
				intervals = 0;
				gaps      = 0;
				grants    = 0;
			end

			if (active)
			begin
				if (cpu_grant && !prev_grant)
					grants++;
				// zneg offset first, it refers to the previous zpos
				if (edges.zneg && last_zpos >= 0 && exp_period != 0 && exp_gap == 0)
				begin
					if (cycle - last_zpos != exp_period / 2)
						value_error("zneg offset", cycle - last_zpos, exp_period / 2);
				end
				if (edges.zpos)
				begin
					if (last_zpos >= 0 && exp_period != 0)
					begin
						intv = cycle - last_zpos;
						intervals++;
						if (exp_gap != 0 && intv >= exp_gap)
							gaps++;
						else if (intv != exp_period)
							value_error("zpos period", intv, exp_period);
					end
					last_zpos = cycle;
				end
			end

			if (!active && was_active)
			begin
				if (int_turbo != exp_turbo)
					value_error("int_turbo", int'(int_turbo), int'(exp_turbo));
				if (exp_period != 0 && intervals < 2)
					text_error("too few zpos pulses to measure the period");
				if (exp_gap != 0 && gaps == 0)
					text_error("no clock gap seen for the external I/O wait");
				if (exp_grant && grants == 0)
					text_error("no cpu_grant seen for the memory cycle");
				report_test(test_name);
			end

			was_active   = active;
			prev_zclk    = zclk_out;
			prev_pending = !bus.mreq_n && int_turbo[1] && !cpu_grant;
			prev_busy    = dram_busy;
			prev_mreq_n  = bus.mreq_n;
			prev_grant   = cpu_grant;
		end
	end

endmodule

//--- verilog.f
verilog/zclk_pkg.sv
verilog/phase_gen.sv
verilog/io_wait_gen.sv
verilog/mem_slot_arb.sv
verilog/zclock.sv
verilog/zclock_top.sv
verification/zclock_checker.sv
verification/tb_zclock.sv

//--- verilog/io_wait_gen.sv
// wait-state generator for external I/O cycles at 14 MHz
// a new I/O cycle seen at zpos starts a counter whose value shapes the stall
// stall pattern: IO_WAIT_LEN cycles high, one low, one high, then released

`timescale 1ns/10ps

module io_wait_gen #(
	parameter int IO_WAIT_LEN = 12
)
(
	input  logic              fclk,
	input  logic              rst_n,
	input  zclk_pkg::zbus_t   bus,
	input  logic              external_port,
	input  zclk_pkg::zedge_t  edges,
	input  zclk_pkg::turbo_t  int_turbo,
	output logic              io_stall
);

	import zclk_pkg::*;

	// last counter value, where the final re-stall cycle sits
	localparam logic [3:0] WAIT_END = 4'(IO_WAIT_LEN + 2);

	logic       io;
	logic       io_r;
	logic       io_start;
	logic [3:0] wait_cnt;

	// external I/O, not an interrupt acknowledge
	assign io = !bus.iorq_n && bus.m1_n && external_port;

	// io only rises once per cycle at a zpos
	assign io_start = io && !io_r && edges.zpos && is_turbo14(int_turbo) && (wait_cnt == 4'd0);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_r     <= 1'b0;
			wait_cnt <= 4'd0;
			io_stall <= 1'b0;
		end
		else
		begin
			if (edges.zpos)
				io_r <= io;

			if (io_start)
				wait_cnt <= 4'd1;
			else if (wait_cnt == WAIT_END)
				wait_cnt <= 4'd0;
			else if (wait_cnt != 4'd0)
				wait_cnt <= wait_cnt + 4'd1;

			// brief release one step before the end, as the external wait sequence expects
			io_stall <= (wait_cnt != 4'd0) && (wait_cnt != 4'(IO_WAIT_LEN + 1));
		end
	end

endmodule

//--- verilog/mem_slot_arb.sv
// memory slot arbiter for CPU cycles at 14 MHz
// an active mreq_n is a pending request, granted at the first c3 with a free DRAM slot
// the grant holds until mreq_n rises, the clock is stalled while the request waits

`timescale 1ns/10ps

module mem_slot_arb
(
	input  logic              fclk,
	input  logic              rst_n,
	input  zclk_pkg::zbus_t   bus,
	input  zclk_pkg::zphase_t phase,
	input  logic              dram_busy,
	input  zclk_pkg::turbo_t  int_turbo,
	output logic              cpu_grant,
	output logic              mem_stall
);

	import zclk_pkg::*;

	logic cpu_req;
	logic slot_free;

	// only 14 MHz cycles need a slot, slower modes always fit in
	assign cpu_req = !bus.mreq_n && is_turbo14(int_turbo);

	// c3 is the CPU slot, video takes it when dram_busy is high
	assign slot_free = phase.c3 && !dram_busy;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cpu_grant <= 1'b0;
		end
		else
		begin
			// set on a free slot, kept while the cycle lasts, dropped when mreq_n rises
			cpu_grant <= cpu_req && (cpu_grant || slot_free);
		end
	end

	// pending request holds the Z80 clock
	// combinational so the very next edge strobe is already suppressed
	assign mem_stall = cpu_req && !cpu_grant;

endmodule

//--- verilog/phase_gen.sv
// free-running four-phase sequencer
// drives one-hot strobes c0..c3, one step per fclk, starting at c0 out of reset

`timescale 1ns/10ps

module phase_gen
(
	input  logic              fclk,
	input  logic              rst_n,
	output zclk_pkg::zphase_t phase
);

	// ring register, bit 3 is c0 and bit 0 is c3
	logic [3:0] ring;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ring <= 4'b1000;
		end
		else
		begin
			// rotate c0 -> c1 -> c2 -> c3 -> c0
			ring <= {ring[0], ring[3:1]};
		end
	end

	// field order of the struct matches the ring bits
	assign phase = ring;

endmodule

//--- verilog/zclk_pkg.sv
// shared types for the Z80 clock subsystem
// speed codes, bus status, phase strobes and clock edge strobes
// every module of the subsystem and the testbench import this package

package zclk_pkg;

	// default length of the continuous external I/O stall, in fclk cycles
	parameter int IO_WAIT_LEN_DEF = 12;

	// speed code, any code with the upper bit set runs at 14 MHz
	typedef enum logic [1:0]
	{
		TURBO_35  = 2'b00,
		TURBO_70  = 2'b01,
		TURBO_140 = 2'b10
	} turbo_t;

	// active low Z80 bus status
	typedef struct packed
	{
		logic mreq_n;
		logic iorq_n;
		logic m1_n;
		logic rfsh_n;
	} zbus_t;

	// one-hot phase strobes, c0 first
	typedef struct packed
	{
		logic c0;
		logic c1;
		logic c2;
		logic c3;
	} zphase_t;

	// single fclk pulses at the Z80 clock edges
	typedef struct packed
	{
		logic zpos;
		logic zneg;
	} zedge_t;

	// upper bit alone selects 14 MHz
	function automatic logic is_turbo14(input turbo_t t);
		return t[1];
	endfunction

endpackage

//--- verilog/zclock.sv
// Z80 clock generator with three speeds and stall
// speed is latched at the falling edge of rfsh_n, sampled at zpos
// zpos and zneg are one-fclk strobes, zclk_out follows them on the fclk negedge
// zclk_out is inverted on the board, so zpos drives it low and zneg high

`timescale 1ns/10ps

module zclock
(
	input  logic              fclk,
	input  logic              rst_n,
	input  zclk_pkg::zphase_t phase,
	input  zclk_pkg::zbus_t   bus,
	input  zclk_pkg::turbo_t  turbo,
	input  logic              io_stall,
	input  logic              mem_stall,
	output zclk_pkg::zedge_t  edges,
	output zclk_pkg::turbo_t  int_turbo,
	output logic              zclk_out
);

	import zclk_pkg::*;

	logic old_rfsh_n;
	logic stall;
	logic clk14_src;
	logic half_c2;
	logic pre_zpos;
	logic pre_zneg;

	// speed switch only in refresh of M1
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			old_rfsh_n <= 1'b1;
			int_turbo  <= TURBO_35;
		end
		else if (edges.zpos)
		begin
			old_rfsh_n <= bus.rfsh_n;
			if (old_rfsh_n && !bus.rfsh_n)
				int_turbo <= turbo;
		end
	end

	assign stall = io_stall || mem_stall;

	// 14 MHz source toggles every fclk, frozen while stalled
	// every other c2 for 3.5 MHz, half_c2 flips at each c2
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			clk14_src <= 1'b0;
			half_c2   <= 1'b0;
		end
		else
		begin
			if (!stall)
				clk14_src <= !clk14_src;
			if (phase.c2)
				half_c2 <= !half_c2;
		end
	end

	// pre-edge selection per speed
	always_comb
	begin
		if (is_turbo14(int_turbo))
		begin
			pre_zpos = clk14_src;
			pre_zneg = !clk14_src;
		end
		else if (int_turbo == TURBO_70)
		begin
			// c2 and c0 are two fclk apart, period is 4
			pre_zpos = phase.c2;
			pre_zneg = phase.c0;
		end
		else
		begin
			// alternate c2 pulses, period is 8 with zneg midway
			pre_zpos = phase.c2 && !half_c2;
			pre_zneg = phase.c2 && half_c2;
		end
	end

	// strobes only when the clock level allows the edge
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			edges <= '0;
		end
		else
		begin
			edges.zpos <= !stall && pre_zpos && zclk_out;
			edges.zneg <= !stall && pre_zneg && !zclk_out;
		end
	end

	// negedge output gives some lead over the next fclk posedge
	always_ff @(negedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			zclk_out <= 1'b0;
		else if (edges.zpos)
			zclk_out <= 1'b0;
		else if (edges.zneg)
			zclk_out <= 1'b1;
	end

endmodule

//--- verilog/zclock_top.sv
// top level of the Z80 clock subsystem
// phase sequencer, I/O wait generator, memory slot arbiter and clock generator
// IO_WAIT_LEN sets the I/O stall length and is passed to the wait generator

`timescale 1ns/10ps

module zclock_top #(
	parameter int IO_WAIT_LEN = zclk_pkg::IO_WAIT_LEN_DEF
)
(
	input  logic              fclk,
	input  logic              rst_n,
	input  zclk_pkg::turbo_t  turbo,
	input  zclk_pkg::zbus_t   bus,
	input  logic              external_port,
	input  logic              dram_busy,
	output logic              zclk_out,
	output zclk_pkg::zedge_t  edges,
	output zclk_pkg::turbo_t  int_turbo,
	output logic              cpu_grant
);

	import zclk_pkg::*;

	zphase_t phase;
	logic    io_stall;
	logic    mem_stall;

	phase_gen phase_gen_i (
		.fclk  (fclk),
		.rst_n (rst_n),
		.phase (phase)
	);

	// stall source for external I/O
	io_wait_gen #(
		.IO_WAIT_LEN (IO_WAIT_LEN)
	) io_wait_gen_i (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.bus           (bus),
		.external_port (external_port),
		.edges         (edges),
		.int_turbo     (int_turbo),
		.io_stall      (io_stall)
	);

	// stall source for DRAM slots
	mem_slot_arb mem_slot_arb_i (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.bus       (bus),
		.phase     (phase),
		.dram_busy (dram_busy),
		.int_turbo (int_turbo),
		.cpu_grant (cpu_grant),
		.mem_stall (mem_stall)
	);

	zclock zclock_i (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.phase     (phase),
		.bus       (bus),
		.turbo     (turbo),
		.io_stall  (io_stall),
		.mem_stall (mem_stall),
		.edges     (edges),
		.int_turbo (int_turbo),
		.zclk_out  (zclk_out)
	);

endmodule
